// File: logic/mem_arb_settings.svh
/* Sizing, local bus register map and fixed data values of the memory arbiter.
   Included by the package and by every module that needs a size or an address. */
`ifndef MEM_ARB_SETTINGS_SVH
`define MEM_ARB_SETTINGS_SVH

// Agent count and controller port widths
`define MEM_ARB_NUM_AGENTS    4
`define MEM_ARB_ADDR_W        16
`define MEM_ARB_DATA_W        32

// Queue sizes
`define MEM_ARB_INGR_DEPTH    4
`define MEM_ARB_TAG_DEPTH     8

// Local bus; partition base of agent i at 2i, its limit at 2i+1
`define MEM_ARB_LB_ADDR_W     8
`define MEM_ARB_LB_DATA_W     32
`define MEM_ARB_REG_STATUS    8'h10

`define MEM_ARB_DEFAULT_DATA  32'hdeadbabe
`define MEM_ARB_POISON_DATA   32'hbadc0de0

`endif

// File: logic/mem_arb_pkg.sv
/* Transaction, read tag and agent id types shared by the arbiter stages.
   Modules take them by a wildcard import in their header. */
`include "mem_arb_settings.svh"

package mem_arb_pkg;

  typedef logic [$clog2(`MEM_ARB_NUM_AGENTS)-1:0] agent_id_t;
  typedef logic [`MEM_ARB_ADDR_W-1:0]             mem_addr_t;
  typedef logic [`MEM_ARB_DATA_W-1:0]             mem_data_t;

  // One agent request as queued in its ingress FIFO
  typedef struct packed {
    logic      wr;
    logic      rd;
    mem_addr_t addr;
    mem_data_t wdata;
  } mem_xtn_t;

  // Outstanding read, in issue order
  typedef struct packed {
    agent_id_t agent;
    logic      poison;
  } rd_tag_t;

endpackage

// File: logic/xtn_fifo.sv
/* Synchronous first-word-fall-through FIFO with a typed payload.
   The head is valid whenever empty is low; pop retires it. */
`timescale 1ns/1ps

module xtn_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     cntrlr_clk,
  input  logic     cntrlr_rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap also works for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign head    = mem[rd_ptr];

  always_ff @(posedge cntrlr_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The writer and the reader live in other blocks and must honour the flags
  a_no_overflow: assert property (@(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    push |-> !full)
    else $error("xtn_fifo push while full");

  a_no_underflow: assert property (@(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    pop |-> !empty)
    else $error("xtn_fifo pop while empty");

endmodule

// File: logic/rr_arb_stage.sv
/* Agent ingress queues and the round-robin pick. One transaction per
   unstalled cycle is popped and registered together with its agent id. */
`timescale 1ns/1ps
`include "mem_arb_settings.svh"

module rr_arb_stage
  import mem_arb_pkg::*;
(
  input  logic                           cntrlr_clk,
  input  logic                           cntrlr_rst_n,
  input  logic [`MEM_ARB_NUM_AGENTS-1:0] agent_wren,
  input  logic [`MEM_ARB_NUM_AGENTS-1:0] agent_rden,
  input  mem_addr_t                      agent_addr [`MEM_ARB_NUM_AGENTS],
  input  mem_data_t                      agent_wdata [`MEM_ARB_NUM_AGENTS],
  output logic [`MEM_ARB_NUM_AGENTS-1:0] agent_wait,
  input  logic                           pipe_stall,
  output logic                           xtn_valid,
  output mem_xtn_t                       xtn,
  output agent_id_t                      xtn_agent
);

  localparam int N = `MEM_ARB_NUM_AGENTS;

  logic [N-1:0] fifo_push;
  logic [N-1:0] fifo_pop;
  logic [N-1:0] fifo_empty;
  logic [N-1:0] fifo_full;
  mem_xtn_t     fifo_din [N];
  mem_xtn_t     fifo_head [N];

  // Next agent in line, one past the last grant
  agent_id_t    rr_ptr;
  agent_id_t    cand;
  agent_id_t    grant;
  logic         pick_valid;
  logic         take;

  for (genvar i = 0; i < N; i++)
  begin : g_ingr
    assign fifo_push[i] = (agent_wren[i] | agent_rden[i]) & ~fifo_full[i];
    assign fifo_din[i]  = '{wr: agent_wren[i], rd: agent_rden[i],
                            addr: agent_addr[i], wdata: agent_wdata[i]};
    assign fifo_pop[i]  = take & (grant == agent_id_t'(i));
    assign agent_wait[i] = fifo_full[i];

    xtn_fifo #(
      .payload_t (mem_xtn_t),
      .DEPTH     (`MEM_ARB_INGR_DEPTH)
    ) u_ingr_fifo (
      .cntrlr_clk   (cntrlr_clk),
      .cntrlr_rst_n (cntrlr_rst_n),
      .push         (fifo_push[i]),
      .push_data    (fifo_din[i]),
      .pop          (fifo_pop[i]),
      .head         (fifo_head[i]),
      .empty        (fifo_empty[i]),
      .full         (fifo_full[i])
    );
  end

  // First non-empty queue at or after the pointer
  always_comb
  begin
    pick_valid = 1'b0;
    grant      = rr_ptr;
    cand       = rr_ptr;
    for (int k = 0; k < N; k++)
    begin
      cand = agent_id_t'((int'(rr_ptr) + k) % N);
      if (!pick_valid && !fifo_empty[cand])
      begin
        pick_valid = 1'b1;
        grant      = cand;
      end
    end
  end

  assign take = pick_valid & ~pipe_stall;

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      xtn_valid <= 1'b0;
      rr_ptr    <= '0;
    end
    else if (!pipe_stall)
    begin
      xtn_valid <= pick_valid;
      if (pick_valid)
        rr_ptr <= agent_id_t'((int'(grant) + 1) % N);
    end
  end

  always_ff @(posedge cntrlr_clk)
  begin
    if (take)
    begin
      xtn       <= fifo_head[grant];
      xtn_agent <= grant;
    end
  end

  a_one_pop: assert property (@(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    $onehot0(fifo_pop))
    else $error("more than one ingress queue popped");

endmodule

// File: logic/partition_reloc_stage.sv
/* Per-agent partition registers on the local bus, address relocation and
   limit check. Violations are counted and readable at the status address. */
`timescale 1ns/1ps
`include "mem_arb_settings.svh"

module partition_reloc_stage
  import mem_arb_pkg::*;
(
  input  logic                          cntrlr_clk,
  input  logic                          cntrlr_rst_n,
  input  logic                          lb_wr_en,
  input  logic                          lb_rd_en,
  input  logic [`MEM_ARB_LB_ADDR_W-1:0] lb_addr,
  input  logic [`MEM_ARB_LB_DATA_W-1:0] lb_wr_data,
  output logic                          lb_wr_valid,
  output logic                          lb_rd_valid,
  output logic [`MEM_ARB_LB_DATA_W-1:0] lb_rd_data,
  input  logic                          xtn_valid,
  input  mem_xtn_t                      xtn,
  input  agent_id_t                     xtn_agent,
  input  logic                          pipe_stall,
  output logic                          reloc_valid,
  output mem_xtn_t                      reloc_xtn,
  output agent_id_t                     reloc_agent,
  output logic                          reloc_viol
);

  localparam int N         = `MEM_ARB_NUM_AGENTS;
  localparam int LB_ADDR_W = `MEM_ARB_LB_ADDR_W;
  localparam int LB_DATA_W = `MEM_ARB_LB_DATA_W;

  mem_addr_t              base_reg [N];
  mem_addr_t              limit_reg [N];
  logic [LB_DATA_W-1:0]   viol_cnt;
  logic [LB_DATA_W-1:0]   lb_rd_mux;
  logic                   lb_part_hit;
  agent_id_t              lb_agent;
  logic                   viol_now;
  mem_xtn_t               reloc_next;

  assign lb_part_hit = (lb_addr < LB_ADDR_W'(2 * N));
  assign lb_agent    = lb_addr[$bits(agent_id_t):1];

  always_comb
  begin
    if (lb_part_hit)
      lb_rd_mux = lb_addr[0] ? LB_DATA_W'(limit_reg[lb_agent])
                             : LB_DATA_W'(base_reg[lb_agent]);
    else if (lb_addr == `MEM_ARB_REG_STATUS)
      lb_rd_mux = viol_cnt;
    else
      lb_rd_mux = `MEM_ARB_DEFAULT_DATA;
  end

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      lb_rd_data  <= '0;
      for (int i = 0; i < N; i++)
      begin
        base_reg[i]  <= '0;
        limit_reg[i] <= '1;
      end
    end
    else
    begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (lb_rd_en)
        lb_rd_data <= lb_rd_mux;
      // Odd addresses hold the limit
      if (lb_wr_en && lb_part_hit)
      begin
        if (lb_addr[0])
          limit_reg[lb_agent] <= lb_wr_data[$bits(mem_addr_t)-1:0];
        else
          base_reg[lb_agent] <= lb_wr_data[$bits(mem_addr_t)-1:0];
      end
    end
  end

  // Agent addresses are offsets into the partition
  assign viol_now = (xtn.addr > limit_reg[xtn_agent]);

  always_comb
  begin
    reloc_next      = xtn;
    reloc_next.addr = xtn.addr + base_reg[xtn_agent];
  end

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
    begin
      reloc_valid <= 1'b0;
      viol_cnt    <= '0;
    end
    else if (!pipe_stall)
    begin
      reloc_valid <= xtn_valid;
      // Saturates instead of wrapping
      if (xtn_valid && viol_now && viol_cnt != '1)
        viol_cnt <= viol_cnt + 1'b1;
    end
  end

  always_ff @(posedge cntrlr_clk)
  begin
    if (!pipe_stall)
    begin
      reloc_xtn   <= reloc_next;
      reloc_agent <= xtn_agent;
      reloc_viol  <= viol_now;
    end
  end

endmodule

// File: logic/cntrlr_issue_stage.sv
/* Holding register in front of the memory controller. It keeps the request on
   the port until cntrlr_rdy and queues a read tag for every read it retires. */
`timescale 1ns/1ps

module cntrlr_issue_stage
  import mem_arb_pkg::*;
(
  input  logic      cntrlr_clk,
  input  logic      cntrlr_rst_n,
  input  logic      reloc_valid,
  input  mem_xtn_t  reloc_xtn,
  input  agent_id_t reloc_agent,
  input  logic      reloc_viol,
  output logic      pipe_stall,
  input  logic      cntrlr_rdy,
  output logic      cntrlr_wren,
  output logic      cntrlr_rden,
  output mem_addr_t cntrlr_addr,
  output mem_data_t cntrlr_wdata,
  output logic      tag_push,
  output rd_tag_t   tag_data,
  input  logic      tag_full
);

  logic      hold_valid;
  mem_xtn_t  hold_xtn;
  agent_id_t hold_agent;
  logic      hold_viol;
  logic      needs_tag;

  // Violating entries never reach the controller, so they never wait on it
  assign needs_tag  = hold_valid & hold_xtn.rd;
  assign pipe_stall = (hold_valid & ~hold_viol & ~cntrlr_rdy) | (needs_tag & tag_full);

  // A read is offered only once its tag has room
  assign cntrlr_wren  = hold_valid & hold_xtn.wr & ~hold_viol;
  assign cntrlr_rden  = needs_tag & ~hold_viol & ~tag_full;
  assign cntrlr_addr  = hold_xtn.addr;
  assign cntrlr_wdata = hold_xtn.wdata;

  // Poison tag for a violating read, normal tag on the issue edge
  assign tag_push = needs_tag & ~pipe_stall;
  assign tag_data = '{agent: hold_agent, poison: hold_viol};

  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
      hold_valid <= 1'b0;
    else if (!pipe_stall)
      hold_valid <= reloc_valid;
  end

  always_ff @(posedge cntrlr_clk)
  begin
    if (!pipe_stall)
    begin
      hold_xtn   <= reloc_xtn;
      hold_agent <= reloc_agent;
      hold_viol  <= reloc_viol;
    end
  end

  a_port_stable: assert property (@(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    (cntrlr_wren || cntrlr_rden) && !cntrlr_rdy |=>
      $stable(cntrlr_wren) && $stable(cntrlr_rden) &&
      $stable(cntrlr_addr) && $stable(cntrlr_wdata))
    else $error("controller request changed before cntrlr_rdy");

endmodule

// File: logic/rd_return_stage.sv
/* Routes read data back to agents in issue order. The tag at the FIFO head
   names the agent; poison tags are answered locally with poison data. */
`timescale 1ns/1ps
`include "mem_arb_settings.svh"

module rd_return_stage
  import mem_arb_pkg::*;
(
  input  logic                           cntrlr_clk,
  input  logic                           cntrlr_rst_n,
  input  logic                           tag_push,
  input  rd_tag_t                        tag_data,
  output logic                           tag_full,
  input  logic                           cntrlr_rd_valid,
  input  mem_data_t                      cntrlr_rdata,
  output logic [`MEM_ARB_NUM_AGENTS-1:0] agent_rd_valid,
  output mem_data_t                      agent_rdata
);

  localparam int N = `MEM_ARB_NUM_AGENTS;

  rd_tag_t tag_head;
  logic    tag_empty;
  logic    poison_fire;
  logic    deliver;

  xtn_fifo #(
    .payload_t (rd_tag_t),
    .DEPTH     (`MEM_ARB_TAG_DEPTH)
  ) u_tag_fifo (
    .cntrlr_clk   (cntrlr_clk),
    .cntrlr_rst_n (cntrlr_rst_n),
    .push         (tag_push),
    .push_data    (tag_data),
    .pop          (deliver),
    .head         (tag_head),
    .empty        (tag_empty),
    .full         (tag_full)
  );

  // Fires one cycle after a poison tag reaches the head, then clears
  always_ff @(posedge cntrlr_clk or negedge cntrlr_rst_n)
  begin
    if (!cntrlr_rst_n)
      poison_fire <= 1'b0;
    else
      poison_fire <= ~tag_empty & tag_head.poison & ~poison_fire;
  end

  assign deliver     = poison_fire | cntrlr_rd_valid;
  assign agent_rdata = poison_fire ? `MEM_ARB_POISON_DATA : cntrlr_rdata;

  for (genvar i = 0; i < N; i++)
  begin : g_route
    assign agent_rd_valid[i] = deliver & (tag_head.agent == agent_id_t'(i));
  end

  // Controller must only answer reads that were actually issued
  a_rd_has_tag: assert property (@(posedge cntrlr_clk) disable iff (!cntrlr_rst_n)
    cntrlr_rd_valid |-> !tag_empty && !tag_head.poison)
    else $error("read data without a matching issued read");

endmodule

// File: logic/mem_arb_top.sv
/* Shared-memory arbiter top: ingress round robin, partition relocation,
   controller issue and read return, all on cntrlr_clk. */
`timescale 1ns/1ps
`include "mem_arb_settings.svh"

module mem_arb_top
  import mem_arb_pkg::*;
(
  input  logic                           cntrlr_clk,
  input  logic                           cntrlr_rst_n,
  // Agents
  input  logic [`MEM_ARB_NUM_AGENTS-1:0] agent_wren,
  input  logic [`MEM_ARB_NUM_AGENTS-1:0] agent_rden,
  input  mem_addr_t                      agent_addr [`MEM_ARB_NUM_AGENTS],
  input  mem_data_t                      agent_wdata [`MEM_ARB_NUM_AGENTS],
  output logic [`MEM_ARB_NUM_AGENTS-1:0] agent_wait,
  output logic [`MEM_ARB_NUM_AGENTS-1:0] agent_rd_valid,
  output mem_data_t                      agent_rdata,
  // Local bus
  input  logic                           lb_wr_en,
  input  logic                           lb_rd_en,
  input  logic [`MEM_ARB_LB_ADDR_W-1:0]  lb_addr,
  input  logic [`MEM_ARB_LB_DATA_W-1:0]  lb_wr_data,
  output logic                           lb_wr_valid,
  output logic                           lb_rd_valid,
  output logic [`MEM_ARB_LB_DATA_W-1:0]  lb_rd_data,
  // Memory controller
  input  logic                           cntrlr_rdy,
  output logic                           cntrlr_wren,
  output logic                           cntrlr_rden,
  output mem_addr_t                      cntrlr_addr,
  output mem_data_t                      cntrlr_wdata,
  input  logic                           cntrlr_rd_valid,
  input  mem_data_t                      cntrlr_rdata
);

  logic      pipe_stall;
  logic      xtn_valid;
  mem_xtn_t  xtn;
  agent_id_t xtn_agent;
  logic      reloc_valid;
  mem_xtn_t  reloc_xtn;
  agent_id_t reloc_agent;
  logic      reloc_viol;
  logic      tag_push;
  rd_tag_t   tag_data;
  logic      tag_full;

  rr_arb_stage u_arb (
    .cntrlr_clk (cntrlr_clk), .cntrlr_rst_n (cntrlr_rst_n),
    .agent_wren (agent_wren), .agent_rden (agent_rden),
    .agent_addr (agent_addr), .agent_wdata (agent_wdata),
    .agent_wait (agent_wait), .pipe_stall (pipe_stall),
    .xtn_valid  (xtn_valid),  .xtn (xtn), .xtn_agent (xtn_agent)
  );

  partition_reloc_stage u_reloc (
    .cntrlr_clk  (cntrlr_clk),  .cntrlr_rst_n (cntrlr_rst_n),
    .lb_wr_en    (lb_wr_en),    .lb_rd_en (lb_rd_en),
    .lb_addr     (lb_addr),     .lb_wr_data (lb_wr_data),
    .lb_wr_valid (lb_wr_valid), .lb_rd_valid (lb_rd_valid), .lb_rd_data (lb_rd_data),
    .xtn_valid   (xtn_valid),   .xtn (xtn), .xtn_agent (xtn_agent),
    .pipe_stall  (pipe_stall),
    .reloc_valid (reloc_valid), .reloc_xtn (reloc_xtn),
    .reloc_agent (reloc_agent), .reloc_viol (reloc_viol)
  );

  cntrlr_issue_stage u_issue (
    .cntrlr_clk  (cntrlr_clk),  .cntrlr_rst_n (cntrlr_rst_n),
    .reloc_valid (reloc_valid), .reloc_xtn (reloc_xtn),
    .reloc_agent (reloc_agent), .reloc_viol (reloc_viol),
    .pipe_stall  (pipe_stall),  .cntrlr_rdy (cntrlr_rdy),
    .cntrlr_wren (cntrlr_wren), .cntrlr_rden (cntrlr_rden),
    .cntrlr_addr (cntrlr_addr), .cntrlr_wdata (cntrlr_wdata),
    .tag_push    (tag_push),    .tag_data (tag_data), .tag_full (tag_full)
  );

  rd_return_stage u_return (
    .cntrlr_clk      (cntrlr_clk),      .cntrlr_rst_n (cntrlr_rst_n),
    .tag_push        (tag_push),        .tag_data (tag_data), .tag_full (tag_full),
    .cntrlr_rd_valid (cntrlr_rd_valid), .cntrlr_rdata (cntrlr_rdata),
    .agent_rd_valid  (agent_rd_valid),  .agent_rdata (agent_rdata)
  );

endmodule

// File: test/mem_arb_tb.sv
/* Directed testbench for the memory arbiter. Agent request queues feed the DUT,
   a controller memory model answers with random ready, and a watchdog bounds the run. */
`timescale 1ns/1ps
`include "mem_arb_settings.svh"

module mem_arb_tb
  import mem_arb_pkg::*;
();

  localparam int N           = `MEM_ARB_NUM_AGENTS;
  localparam int CLK_PERIOD  = 8;
  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 2000;
  localparam int QD          = 64;
  localparam int LOG_DEPTH   = 256;

  typedef logic [`MEM_ARB_LB_ADDR_W-1:0] lb_addr_t;
  typedef logic [`MEM_ARB_LB_DATA_W-1:0] lb_word_t;

  logic         cntrlr_clk = 1'b0;
  logic         cntrlr_rst_n;
  logic [N-1:0] agent_wren = '0;
  logic [N-1:0] agent_rden = '0;
  mem_addr_t    agent_addr [N] = '{default: '0};
  mem_data_t    agent_wdata [N] = '{default: '0};
  logic [N-1:0] agent_wait;
  logic [N-1:0] agent_rd_valid;
  mem_data_t    agent_rdata;
  logic         lb_wr_en;
  logic         lb_rd_en;
  lb_addr_t     lb_addr;
  lb_word_t     lb_wr_data;
  logic         lb_wr_valid;
  logic         lb_rd_valid;
  lb_word_t     lb_rd_data;
  logic         cntrlr_rdy = 1'b1;
  logic         cntrlr_wren;
  logic         cntrlr_rden;
  mem_addr_t    cntrlr_addr;
  mem_data_t    cntrlr_wdata;
  logic         cntrlr_rd_valid = 1'b0;
  mem_data_t    cntrlr_rdata = '0;

  // Per-agent request queues and expected read data in program order
  mem_xtn_t     req_q [N][QD];
  int           req_head [N] = '{default: 0};
  int           req_tail [N] = '{default: 0};
  mem_data_t    exp_rd [N][QD];
  int           exp_head [N] = '{default: 0};
  int           exp_tail [N] = '{default: 0};

  // Everything the controller accepted in issue order
  logic         iss_wr [LOG_DEPTH];
  mem_addr_t    iss_addr [LOG_DEPTH];
  mem_data_t    iss_data [LOG_DEPTH];
  int           iss_cnt = 0;
  int           iss_expected = 0;

  mem_data_t    ctl_mem [2**`MEM_ARB_ADDR_W];
  logic         rd_pend_v = 1'b0;
  mem_data_t    rd_pend_d = '0;
  logic         rand_rdy = 1'b0;
  int unsigned  lcg_state = 93;

  mem_arb_top dut0 (
    .cntrlr_clk (cntrlr_clk), .cntrlr_rst_n (cntrlr_rst_n),
    .agent_wren (agent_wren), .agent_rden (agent_rden),
    .agent_addr (agent_addr), .agent_wdata (agent_wdata),
    .agent_wait (agent_wait), .agent_rd_valid (agent_rd_valid),
    .agent_rdata (agent_rdata),
    .lb_wr_en (lb_wr_en), .lb_rd_en (lb_rd_en), .lb_addr (lb_addr),
    .lb_wr_data (lb_wr_data), .lb_wr_valid (lb_wr_valid),
    .lb_rd_valid (lb_rd_valid), .lb_rd_data (lb_rd_data),
    .cntrlr_rdy (cntrlr_rdy), .cntrlr_wren (cntrlr_wren), .cntrlr_rden (cntrlr_rden),
    .cntrlr_addr (cntrlr_addr), .cntrlr_wdata (cntrlr_wdata),
    .cntrlr_rd_valid (cntrlr_rd_valid), .cntrlr_rdata (cntrlr_rdata)
  );

  always #(CLK_PERIOD / 2) cntrlr_clk = ~cntrlr_clk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_data(input string name, input mem_data_t got, input mem_data_t exp);
    if (got !== exp)
      stop_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got !== exp)
      stop_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_lb(input string name, input lb_word_t got, input lb_word_t exp);
    if (got !== exp)
      stop_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp)
      stop_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_strobe(input logic got, input logic exp, input string why);
    if (got !== exp)
      stop_run(why);
  endtask

  // One-cycle strobe whose valid must rise exactly one edge later
  task automatic write_lb_reg(input lb_addr_t addr, input lb_word_t data);
    @(posedge cntrlr_clk);
    lb_wr_en   <= 1'b1;
    lb_addr    <= addr;
    lb_wr_data <= data;
    @(posedge cntrlr_clk);
    lb_wr_en <= 1'b0;
    check_strobe(lb_wr_valid, 1'b0, "lb_wr_valid rose in the same cycle as lb_wr_en");
    @(posedge cntrlr_clk);
    check_strobe(lb_wr_valid, 1'b1, "lb_wr_valid did not follow lb_wr_en by one cycle");
  endtask

  task automatic read_lb_reg(input lb_addr_t addr, input lb_word_t exp);
    @(posedge cntrlr_clk);
    lb_rd_en <= 1'b1;
    lb_addr  <= addr;
    @(posedge cntrlr_clk);
    lb_rd_en <= 1'b0;
    check_strobe(lb_rd_valid, 1'b0, "lb_rd_valid rose in the same cycle as lb_rd_en");
    @(posedge cntrlr_clk);
    check_strobe(lb_rd_valid, 1'b1, "lb_rd_valid did not follow lb_rd_en by one cycle");
    compare_lb($sformatf("lb_rd_data@%h", addr), lb_rd_data, exp);
  endtask

  task automatic queue_write(input int agent, input mem_addr_t off, input mem_data_t data);
    req_q[agent][req_tail[agent]] = '{wr: 1'b1, rd: 1'b0, addr: off, wdata: data};
    req_tail[agent] = req_tail[agent] + 1;
  endtask

  task automatic queue_read(input int agent, input mem_addr_t off, input mem_data_t exp);
    req_q[agent][req_tail[agent]] = '{wr: 1'b0, rd: 1'b1, addr: off, wdata: '0};
    req_tail[agent] = req_tail[agent] + 1;
    exp_rd[agent][exp_tail[agent]] = exp;
    exp_tail[agent] = exp_tail[agent] + 1;
  endtask

  // Until every request is taken, every read answered and every issue seen
  task automatic wait_drain();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge cntrlr_clk);
      if (iss_cnt > iss_expected)
        stop_run("more transactions reached the controller than were posted");
      else
      begin
        busy = (iss_cnt != iss_expected);
        for (int i = 0; i < N; i++)
          if (req_head[i] != req_tail[i] || exp_head[i] != exp_tail[i])
            busy = 1'b1;
      end
    end
  endtask

  // Each agent presents its queue head until it is taken
  always @(posedge cntrlr_clk)
  begin
    for (int i = 0; i < N; i++)
    begin
      if ((agent_wren[i] || agent_rden[i]) && !agent_wait[i])
        req_head[i] = req_head[i] + 1;
      if (req_head[i] < req_tail[i])
      begin
        agent_wren[i]  <= req_q[i][req_head[i]].wr;
        agent_rden[i]  <= req_q[i][req_head[i]].rd;
        agent_addr[i]  <= req_q[i][req_head[i]].addr;
        agent_wdata[i] <= req_q[i][req_head[i]].wdata;
      end
      else
      begin
        agent_wren[i] <= 1'b0;
        agent_rden[i] <= 1'b0;
      end
    end
  end

  // Controller model writes on issue and returns reads in order two edges later
  always @(posedge cntrlr_clk)
  begin : ctl_model
    int unsigned r;
    if ((cntrlr_wren || cntrlr_rden) && cntrlr_rdy)
    begin
      iss_wr[iss_cnt]   = cntrlr_wren;
      iss_addr[iss_cnt] = cntrlr_addr;
      iss_data[iss_cnt] = cntrlr_wdata;
      iss_cnt = iss_cnt + 1;
      if (cntrlr_wren)
        ctl_mem[cntrlr_addr] <= cntrlr_wdata;
    end
    rd_pend_v       <= cntrlr_rden && cntrlr_rdy;
    rd_pend_d       <= ctl_mem[cntrlr_addr];
    cntrlr_rd_valid <= rd_pend_v;
    cntrlr_rdata    <= rd_pend_d;
    if (rand_rdy)
    begin
      r = lcg_next();
      cntrlr_rdy <= r[17] | r[20];
    end
    else
      cntrlr_rdy <= 1'b1;
  end

  always @(posedge cntrlr_clk)
  begin
    for (int i = 0; i < N; i++)
    begin
      if (cntrlr_rst_n && agent_rd_valid[i])
      begin
        if (exp_head[i] >= exp_tail[i])
          stop_run($sformatf("agent %0d received read data it never asked for", i));
        else
        begin
          compare_data($sformatf("agent_rdata[%0d]", i), agent_rdata, exp_rd[i][exp_head[i]]);
          exp_head[i] = exp_head[i] + 1;
        end
      end
    end
  end

  task automatic local_bus_test();
    read_lb_reg(`MEM_ARB_REG_STATUS, '0);
    read_lb_reg(8'h20, `MEM_ARB_DEFAULT_DATA);
    write_lb_reg(8'h02, 32'h0000_1234);
    read_lb_reg(8'h02, 32'h0000_1234);
    write_lb_reg(8'h03, 32'h0000_0abc);
    read_lb_reg(8'h03, 32'h0000_0abc);
    // Untouched limit still holds its reset value
    read_lb_reg(8'h05, 32'h0000_ffff);
  endtask

  // Agent i gets the partition at i*0x1000 with a 4 KiB limit
  task automatic relocation_test();
    mem_addr_t off;
    mem_data_t d;
    int        w;
    for (int i = 0; i < N; i++)
    begin
      write_lb_reg(lb_addr_t'(2 * i), lb_word_t'(i * 'h1000));
      write_lb_reg(lb_addr_t'(2 * i + 1), 32'h0000_0fff);
    end
    for (int i = 0; i < N; i++)
    begin
      @(negedge cntrlr_clk);
      off = mem_addr_t'('h20 + i);
      d   = lcg_next();
      w   = iss_expected;
      queue_write(i, off, d);
      queue_read(i, off, d);
      iss_expected = iss_expected + 2;
      wait_drain();
      compare_count("cntrlr_wren of write", int'(iss_wr[w]), 1);
      compare_addr("cntrlr_addr of write", iss_addr[w], mem_addr_t'(i * 'h1000) + off);
      compare_data("cntrlr_wdata", iss_data[w], d);
      compare_count("cntrlr_wren of read", int'(iss_wr[w + 1]), 0);
      compare_addr("cntrlr_addr of read", iss_addr[w + 1], mem_addr_t'(i * 'h1000) + off);
    end
  endtask

  // The last grant went to agent 3, so rotation starts again at agent 0
  task automatic fairness_test();
    int first;
    @(negedge cntrlr_clk);
    first = iss_expected;
    for (int k = 0; k < 4; k++)
      for (int i = 0; i < N; i++)
        queue_write(i, mem_addr_t'('h40 + k), {16'(i), 16'(k)});
    iss_expected = iss_expected + 4 * N;
    wait_drain();
    for (int k = 0; k < 4 * N; k++)
      compare_addr("cntrlr_addr partition", iss_addr[first + k] & 16'hf000,
                   mem_addr_t'((k % N) * 'h1000));
  endtask

  // Each agent's write and read pairs reach the controller once and in order
  task automatic backpressure_test();
    int        first;
    int        agent;
    int        seen [N];
    mem_data_t d;
    @(negedge cntrlr_clk);
    rand_rdy = 1'b1;
    first    = iss_expected;
    for (int i = 0; i < N; i++)
      seen[i] = 0;
    for (int i = 0; i < N; i++)
      for (int k = 0; k < 8; k++)
      begin
        d = lcg_next();
        queue_write(i, mem_addr_t'('h100 + k), d);
        queue_read(i, mem_addr_t'('h100 + k), d);
      end
    iss_expected = iss_expected + 16 * N;
    wait_drain();
    rand_rdy = 1'b0;
    for (int k = first; k < iss_cnt; k++)
    begin
      agent = int'(iss_addr[k] >> 12);
      if (agent >= N)
        stop_run($sformatf("issued address %h lies in no agent partition", iss_addr[k]));
      else
      begin
        compare_count($sformatf("cntrlr_wren of agent %0d", agent), int'(iss_wr[k]),
                      1 - seen[agent] % 2);
        compare_addr($sformatf("cntrlr_addr of agent %0d", agent), iss_addr[k],
                     mem_addr_t'(agent * 'h1000 + 'h100 + seen[agent] / 2));
        seen[agent] = seen[agent] + 1;
      end
    end
  endtask

  // Agent 2 has base 0x2000 and its poison answers keep their place among normal reads
  task automatic violation_test();
    @(negedge cntrlr_clk);
    queue_write(2, 16'h0010, 32'h5a5a_0010);
    queue_read(2, 16'h0010, 32'h5a5a_0010);
    queue_read(2, 16'h1000, `MEM_ARB_POISON_DATA);
    iss_expected = iss_expected + 2;
    wait_drain();
    compare_addr("cntrlr_addr", iss_addr[iss_expected - 1], 16'h2010);
    read_lb_reg(`MEM_ARB_REG_STATUS, 32'd1);
    @(negedge cntrlr_clk);
    queue_write(2, 16'h1800, 32'h0bad_0bad);
    queue_read(2, 16'h2000, `MEM_ARB_POISON_DATA);
    queue_read(2, 16'h0010, 32'h5a5a_0010);
    iss_expected = iss_expected + 1;
    wait_drain();
    compare_addr("cntrlr_addr", iss_addr[iss_expected - 1], 16'h2010);
    read_lb_reg(`MEM_ARB_REG_STATUS, 32'd3);
    compare_count("issued transactions", iss_cnt, iss_expected);
  endtask

  initial
  begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    stop_run("watchdog expired before the tests completed");
  end

  initial
  begin
    cntrlr_rst_n = 1'b0;
    lb_wr_en     = 1'b0;
    lb_rd_en     = 1'b0;
    lb_addr      = '0;
    lb_wr_data   = '0;
    repeat (3) @(posedge cntrlr_clk);
    cntrlr_rst_n <= 1'b1;
    local_bus_test();
    relocation_test();
    fairness_test();
    backpressure_test();
    violation_test();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: mem_arb.f
+incdir+logic
logic/mem_arb_pkg.sv
logic/xtn_fifo.sv
logic/rr_arb_stage.sv
logic/partition_reloc_stage.sv
logic/cntrlr_issue_stage.sv
logic/rd_return_stage.sv
logic/mem_arb_top.sv
test/mem_arb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the arbiter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_arb_tb -Mdir obj_dir -o mem_arb_sim \
  -f mem_arb.f || { echo "Verilator build failed"; exit 1; }

./obj_dir/mem_arb_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "Simulation finished: FAIL" "$LOG" && { echo "Result: failed"; exit 1; }
grep -q "Simulation finished: PASS" "$LOG" || { echo "Result: no pass message in log"; exit 1; }
echo "Result: passed"
exit 0
